/* smc_lite.f */
hdl/smc_lite_pkg.sv
hdl/smc_host_port.sv
hdl/smc_mac.sv
hdl/smc_timing_counters.sv
hdl/smc_state.sv
hdl/smc_strobe_gen.sv
hdl/smc_lite.sv
test/sram_model.sv
test/tb_smc_lite.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the smc_lite testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f smc_lite.f \
  --top-module tb_smc_lite \
  -o sim_smc_lite

./obj_dir/sim_smc_lite

/* test/tb_smc_lite.sv */
// Testbench for the static memory controller
// Clock, reset, host stimulus over four timing settings
// Shadow memory scoreboard and strobe timing checks
`timescale 1ns/1ns

module tb_smc_lite;

  localparam int max_cycles = 40 * 4 * 14 + 1000;  // Accesses x beats x worst beat

  logic        sys_clk8;
  logic        n_sys_reset8;
  logic        host_req, host_write, host_bank;
  logic [1:0]  host_size;
  logic [15:0] host_addr;
  logic [31:0] host_wdata;
  logic        host_ready, host_done;
  logic [31:0] host_rdata;
  logic [1:0]  cfg_csle, cfg_cste, cfg_oete;
  logic [7:0]  cfg_ws;
  logic [15:0] mem_addr;
  logic [7:0]  mem_wdata, mem_rdata;
  logic [1:0]  mem_cs_n;
  logic        mem_oe_n, mem_we_n;

  integer      seed;
  int          cycles;
  logic [7:0]  shadow [0:511];
  // Issued accesses, oldest first
  logic        q_write [$];
  logic        q_bank [$];
  int          q_beats [$];
  logic [15:0] q_addr [$];
  logic [31:0] q_data [$];  // Write data or expected read data

  smc_lite u_dut (.*);

  sram_model u_mem (
    .mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_cs_n (mem_cs_n),
    .mem_oe_n (mem_oe_n), .mem_we_n (mem_we_n), .mem_rdata (mem_rdata)
  );

  always #10 sys_clk8 = ~sys_clk8;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  function automatic int beats_of(input logic [1:0] size);
    if (size == smc_lite_pkg::size_word)
      return 4;
    return (size == smc_lite_pkg::size_half) ? 2 : 1;
  endfunction

  //--------------------------------------------------------------------
  // Host request, called 2 ns after a rising edge
  //--------------------------------------------------------------------
  task automatic issue_access(input logic wr, input logic bank, input logic [1:0] size,
                              input logic [15:0] addr);
    logic [31:0] data;
    int          beats;
    beats = beats_of(size);
    data  = $random(seed);
    while (!host_ready)
    begin
      @(posedge sys_clk8);
      #2;
    end
    for (int k = 0; k < 4; k++)
    begin
      if (k >= beats)
        data[k*8 +: 8] = 8'h00;  // Unused lanes
      else if (wr)
        shadow[{bank, 8'(addr + k)}] = data[k*8 +: 8];
      else
        data[k*8 +: 8] = shadow[{bank, 8'(addr + k)}];  // Little-endian
    end
    q_write.push_back(wr);
    q_bank.push_back(bank);
    q_beats.push_back(beats);
    q_addr.push_back(addr);
    q_data.push_back(data);
    host_req   = 1'b1;
    host_write = wr;
    host_bank  = bank;
    host_size  = size;
    host_addr  = addr;
    host_wdata = wr ? data : 32'h0;
    @(posedge sys_clk8);
    #2;
    host_req = 1'b0;
  endtask

  task automatic wait_drained;
    while (q_write.size() != 0 || !host_ready)
      @(posedge sys_clk8);
    repeat (3) @(posedge sys_clk8);
    #2;
  endtask

  task automatic check_quiet;
    assert (host_ready && !host_done && mem_cs_n == 2'b11 && mem_oe_n && mem_we_n)
    else
      stop_run("Controller not idle: host_ready low, host_done high or a strobe low");
  endtask

  //--------------------------------------------------------------------
  // Checkers, sampled at the rising edge
  //--------------------------------------------------------------------
  logic        prev_cs_low, prev_strobe, prev_we_n;
  logic        since_cs;     // Chip select fell since the last strobe rise
  int          gap;          // Strobe-off cycles since the last event
  int          falls;        // Strobe falls in the current access
  int          we_falls;     // Write strobe falls in the current access
  int          we_len;       // Cycles of the current write strobe

  always @(posedge sys_clk8)
  begin
    logic        cs_low;
    logic        strobe;
    logic [31:0] mask;
    logic [31:0] rd_exp;
    cs_low = (mem_cs_n != 2'b11);
    strobe = !mem_oe_n || !mem_we_n;
    if (n_sys_reset8)
    begin
      cycles++;
      if (cycles > max_cycles)
        stop_run("Timeout, an access did not finish in time");
      assert (mem_cs_n != 2'b00 && !(!mem_oe_n && !mem_we_n) && (cs_low || !strobe))
      else
        stop_run("Strobe overlap, or a strobe low with no chip select");
      if (cs_low)
      begin
        assert (q_bank.size() != 0)
        else
          stop_run("Chip select low with no access outstanding");
        assert (mem_cs_n == (q_bank[0] ? 2'b01 : 2'b10))
        else
        begin
          $display("error: mem_cs_n expected 0x%h actual 0x%h",
                   q_bank[0] ? 2'b01 : 2'b10, mem_cs_n);
          stop_run("Wrong bank selected");
        end
      end
      // Completed access
      if (host_done)
      begin
        if (q_write.size() == 0)
          stop_run("host_done with no access outstanding");
        mask = (q_beats[0] == 4) ? 32'hffff_ffff :
               (q_beats[0] == 2) ? 32'h0000_ffff : 32'h0000_00ff;
        rd_exp = q_data[0];
        if (!q_write[0])
        begin
          assert ((host_rdata & mask) == rd_exp)
          else
          begin
            $display("error: host_rdata expected 0x%h actual 0x%h", rd_exp,
                     host_rdata & mask);
            stop_run("Read data mismatch");
          end
        end
        else
        begin
          for (int k = 0; k < q_beats[0]; k++)
            assert (u_mem.mem[{q_bank[0], 8'(q_addr[0] + k)}] == rd_exp[k*8 +: 8])
            else
            begin
              $display("error: mem byte %0d expected 0x%h actual 0x%h", k,
                       rd_exp[k*8 +: 8], u_mem.mem[{q_bank[0], 8'(q_addr[0] + k)}]);
              stop_run("Write data mismatch");
            end
        end
        assert (we_falls == (q_write[0] ? q_beats[0] : 0))
        else
        begin
          $display("error: mem_we_n falls expected 0x%h actual 0x%h",
                   q_write[0] ? q_beats[0] : 0, we_falls);
          stop_run("Write beat count");
        end
        void'(q_write.pop_front());
        void'(q_bank.pop_front());
        void'(q_beats.pop_front());
        void'(q_addr.pop_front());
        void'(q_data.pop_front());
        falls    = 0;
        we_falls = 0;
      end
      // Leading edge spacing
      if (cs_low && !prev_cs_low)
      begin
        gap      = 0;
        since_cs = 1'b1;
      end
      if (!strobe && prev_strobe)
      begin
        gap      = 0;
        since_cs = 1'b0;
      end
      if (strobe && !prev_strobe)
      begin
        if (since_cs || falls > 0)
        begin
          assert (gap >= cfg_csle)
          else
          begin
            $display("error: leading edge expected 0x%h actual 0x%h", cfg_csle, gap);
            stop_run("Strobe fell too early");
          end
        end
        falls++;
      end
      else if (!strobe)
        gap++;
      // Write strobe length
      if (!mem_we_n && prev_we_n)
        we_falls++;
      if (!mem_we_n)
        we_len++;
      else if (!prev_we_n)
      begin
        assert (we_len == cfg_ws + 1)
        else
        begin
          $display("error: mem_we_n low cycles expected 0x%h actual 0x%h",
                   cfg_ws + 1, we_len);
          stop_run("Write strobe length");
        end
        we_len = 0;
      end
    end
    prev_cs_low = cs_low;
    prev_strobe = strobe;
    prev_we_n   = mem_we_n;
  end

  //--------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------
  initial
  begin
    logic [1:0]  csle_l [4] = '{2'd0, 2'd1, 2'd3, 2'd2};
    logic [1:0]  cste_l [4] = '{2'd1, 2'd1, 2'd2, 2'd3};  // Never zero
    logic [1:0]  oete_l [4] = '{2'd0, 2'd1, 2'd2, 2'd1};  // Not above wait states
    logic [7:0]  ws_l   [4] = '{8'd0, 8'd2, 8'd3, 8'd1};
    logic [31:0] r;
    seed         = 32'h78a1_505a;
    sys_clk8     = 1'b0;
    n_sys_reset8 = 1'b0;
    host_req     = 1'b0;
    host_write   = 1'b0;
    host_bank    = 1'b0;
    host_size    = 2'b00;
    host_addr    = 16'h0;
    host_wdata   = 32'h0;
    cfg_csle     = 2'd0;
    cfg_cste     = 2'd1;
    cfg_oete     = 2'd0;
    cfg_ws       = 8'd0;
    cycles       = 0;
    prev_cs_low  = 1'b0;
    prev_strobe  = 1'b0;
    prev_we_n    = 1'b1;
    since_cs     = 1'b0;
    gap          = 0;
    falls        = 0;
    we_falls     = 0;
    we_len       = 0;
    for (int i = 0; i < 512; i++)
      shadow[i] = 8'((i * 37) ^ (i >> 3));  // Same fill as the memory model
    repeat (4) @(posedge sys_clk8);
    #2;
    n_sys_reset8 = 1'b1;
    @(posedge sys_clk8);
    #2;
    check_quiet();
    for (int g = 0; g < 4; g++)
    begin
      cfg_csle = csle_l[g];
      cfg_cste = cste_l[g];
      cfg_oete = oete_l[g];
      cfg_ws   = ws_l[g];
      for (int i = 0; i < 10; i++)
      begin
        r = $random(seed);
        // Small address range so reads hit earlier writes
        issue_access(r[8] | (i < 3), r[9], 2'(i % 3), {10'h0, r[5:0]});
      end
      wait_drained();
    end
    check_quiet();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* test/sram_model.sv */
// Behavioral asynchronous byte SRAM
// Two banks of 256 bytes, selected by the active-low chip selects
// Write at the end of the write strobe, read data only under output enable
`timescale 1ns/1ns

module sram_model (
  input  logic [15:0] mem_addr,
  input  logic [7:0]  mem_wdata,
  input  logic [1:0]  mem_cs_n,
  input  logic        mem_oe_n,   // Read data driven only while low
  input  logic        mem_we_n,
  output logic [7:0]  mem_rdata
);

  logic [7:0] mem [0:511];  // Bank in bit 8
  logic [8:0] idx;

  assign idx       = {~mem_cs_n[1], mem_addr[7:0]};
  // Released bus reads as zero
  assign mem_rdata = (!mem_oe_n && mem_cs_n != 2'b11) ? mem[idx] : 8'h00;

  // Fill depends on bank and byte address
  initial
  begin
    for (int i = 0; i < 512; i++)
      mem[i] = 8'((i * 37) ^ (i >> 3));
  end

  // Address and data stay stable across the strobe rise
  always @(posedge mem_we_n)
  begin
    if (mem_cs_n != 2'b11)
      mem[idx] <= mem_wdata;
  end

endmodule

/* hdl/smc_lite.sv */
// Static memory controller top level
// Host port, multiple access unit, timing counters, FSM, strobes
`timescale 1ns/1ns

module smc_lite (
  input  logic                                 sys_clk8,
  input  logic                                 n_sys_reset8,
  input  logic                                 host_req,
  input  logic                                 host_write,
  input  logic                                 host_bank,
  input  logic [1:0]                           host_size,
  input  logic [smc_lite_pkg::host_addr_w-1:0] host_addr,
  input  logic [smc_lite_pkg::host_data_w-1:0] host_wdata,
  output logic                                 host_ready,
  output logic                                 host_done,
  output logic [smc_lite_pkg::host_data_w-1:0] host_rdata,
  input  logic [smc_lite_pkg::edge_w-1:0]      cfg_csle,
  input  logic [smc_lite_pkg::edge_w-1:0]      cfg_cste,
  input  logic [smc_lite_pkg::edge_w-1:0]      cfg_oete,
  input  logic [smc_lite_pkg::ws_w-1:0]        cfg_ws,
  output logic [smc_lite_pkg::host_addr_w-1:0] mem_addr,
  output logic [smc_lite_pkg::mem_data_w-1:0]  mem_wdata,
  output logic [1:0]                           mem_cs_n,
  output logic                                 mem_oe_n,
  output logic                                 mem_we_n,
  input  logic [smc_lite_pkg::mem_data_w-1:0]  mem_rdata
);

  // Pending request
  logic                                 new_access, n_read, n_r_read, cs, r_cs;
  logic [1:0]                           req_size;
  logic [smc_lite_pkg::host_addr_w-1:0] req_addr;
  logic [smc_lite_pkg::host_data_w-1:0] req_wdata;
  // FSM handshakes
  logic valid_access, mac_done, smc_done, latch_data;
  logic le_enable, ws_enable, cste_enable;
  smc_lite_pkg::smc_state_t             r_smc_currentstate, smc_nextstate;
  // Live counts and stored settings
  logic [smc_lite_pkg::edge_w-1:0]      r_csle_count, r_cste_count;
  logic [smc_lite_pkg::edge_w-1:0]      r_csle_store, r_oete_store;
  logic [smc_lite_pkg::ws_w-1:0]        r_ws_count;

  smc_host_port u_host_port (
    .sys_clk8 (sys_clk8), .n_sys_reset8 (n_sys_reset8),
    .host_req (host_req), .host_write (host_write), .host_bank (host_bank),
    .host_size (host_size), .host_addr (host_addr), .host_wdata (host_wdata),
    .valid_access (valid_access), .new_access (new_access),
    .n_read (n_read), .n_r_read (n_r_read), .cs (cs), .r_cs (r_cs),
    .host_ready (host_ready), .req_size (req_size),
    .req_addr (req_addr), .req_wdata (req_wdata)
  );

  smc_mac u_mac (
    .sys_clk8 (sys_clk8), .n_sys_reset8 (n_sys_reset8),
    .valid_access (valid_access), .smc_done (smc_done), .latch_data (latch_data),
    .req_size (req_size), .req_addr (req_addr), .req_wdata (req_wdata),
    .n_read (n_read), .mem_rdata (mem_rdata), .mac_done (mac_done),
    .mem_addr (mem_addr), .mem_wdata (mem_wdata),
    .host_rdata (host_rdata), .host_done (host_done)
  );

  smc_timing_counters u_timing_counters (
    .sys_clk8 (sys_clk8), .n_sys_reset8 (n_sys_reset8),
    .valid_access (valid_access), .le_enable (le_enable),
    .ws_enable (ws_enable), .cste_enable (cste_enable),
    .r_smc_currentstate (r_smc_currentstate),
    .cfg_csle (cfg_csle), .cfg_cste (cfg_cste), .cfg_oete (cfg_oete), .cfg_ws (cfg_ws),
    .r_csle_count (r_csle_count), .r_cste_count (r_cste_count),
    .r_ws_count (r_ws_count), .r_csle_store (r_csle_store), .r_oete_store (r_oete_store)
  );

  smc_state u_state (
    .sys_clk8 (sys_clk8), .n_sys_reset8 (n_sys_reset8),
    .new_access (new_access), .r_cste_count (r_cste_count),
    .r_csle_count (r_csle_count), .r_ws_count (r_ws_count), .mac_done (mac_done),
    .n_read (n_read), .n_r_read (n_r_read),
    .r_csle_store (r_csle_store), .r_oete_store (r_oete_store),
    .cs (cs), .r_cs (r_cs),
    .r_smc_currentstate (r_smc_currentstate), .smc_nextstate (smc_nextstate),
    .cste_enable (cste_enable), .ws_enable (ws_enable), .smc_done (smc_done),
    .valid_access (valid_access), .le_enable (le_enable), .latch_data (latch_data),
    .smc_idle ()  // Idle flag has no user in this top level
  );

  smc_strobe_gen u_strobe_gen (
    .sys_clk8 (sys_clk8), .n_sys_reset8 (n_sys_reset8),
    .smc_nextstate (smc_nextstate), .r_ws_count (r_ws_count),
    .r_oete_store (r_oete_store), .n_r_read (n_r_read), .r_cs (r_cs),
    .mem_cs_n (mem_cs_n), .mem_oe_n (mem_oe_n), .mem_we_n (mem_we_n)
  );

endmodule

/* hdl/smc_strobe_gen.sv */
// Memory strobe generator
// Registered chip selects, output enable and write enable
`timescale 1ns/1ns

module smc_strobe_gen (
  input  logic                            sys_clk8,
  input  logic                            n_sys_reset8,
  input  smc_lite_pkg::smc_state_t        smc_nextstate,
  input  logic [smc_lite_pkg::ws_w-1:0]   r_ws_count,
  input  logic [smc_lite_pkg::edge_w-1:0] r_oete_store,
  input  logic                            n_r_read,
  input  logic                            r_cs,
  output logic [1:0]                      mem_cs_n,  // One per bank
  output logic                            mem_oe_n,
  output logic                            mem_we_n
);

  logic cs_on;  // Chip select wanted next cycle
  logic oe_on;
  logic we_on;
  logic to_rw;

  assign to_rw = (smc_nextstate == smc_lite_pkg::st_rw);
  assign cs_on = (smc_nextstate == smc_lite_pkg::st_le) | to_rw |
                 (smc_nextstate == smc_lite_pkg::st_float);
  assign we_on = to_rw & n_r_read;
  // Zero count means rw is being entered, else stop oete cycles early
  assign oe_on = to_rw & ~n_r_read &
                 ((r_ws_count == '0) | (r_ws_count > r_oete_store));

  // Pins straight from flops, no decode glitches
  always_ff @(posedge sys_clk8 or negedge n_sys_reset8)
  begin
    if (!n_sys_reset8)
    begin
      mem_cs_n <= 2'b11;
      mem_oe_n <= 1'b1;
      mem_we_n <= 1'b1;
    end
    else
    begin
      mem_cs_n[0] <= ~(cs_on & ~r_cs);
      mem_cs_n[1] <= ~(cs_on & r_cs);
      mem_oe_n    <= ~oe_on;
      mem_we_n    <= ~we_on;
    end
  end

endmodule

/* hdl/smc_state.sv */
// Access state machine
// Next state decode over idle, store, le, rw and float
// Counter enables, beat done, read latch and access load strobes
`timescale 1ns/1ns

module smc_state (
  input  logic                            sys_clk8,
  input  logic                            n_sys_reset8,
  input  logic                            new_access,    // Request pending
  input  logic [smc_lite_pkg::edge_w-1:0] r_cste_count,
  input  logic [smc_lite_pkg::edge_w-1:0] r_csle_count,
  input  logic [smc_lite_pkg::ws_w-1:0]   r_ws_count,
  input  logic                            mac_done,      // Last beat of access
  input  logic                            n_read,
  input  logic                            n_r_read,
  input  logic [smc_lite_pkg::edge_w-1:0] r_csle_store,
  input  logic [smc_lite_pkg::edge_w-1:0] r_oete_store,
  input  logic                            cs,
  input  logic                            r_cs,
  output smc_lite_pkg::smc_state_t        r_smc_currentstate,
  output smc_lite_pkg::smc_state_t        smc_nextstate,
  output logic                            cste_enable,
  output logic                            ws_enable,
  output logic                            smc_done,
  output logic                            valid_access,
  output logic                            le_enable,
  output logic                            latch_data,
  output logic                            smc_idle
);

  logic                      turnaround;  // Direction or bank change
  logic                      ws_zero;
  logic                      cste_zero;
  smc_lite_pkg::smc_state_t  follow;      // Where a finished beat goes

  assign ws_zero    = (r_ws_count == '0);
  assign cste_zero  = (r_cste_count == '0);
  assign turnaround = (n_read != n_r_read) | (cs != r_cs);

  //--------------------------------------------------------------------
  // Beat completion and access load
  //--------------------------------------------------------------------
  assign smc_done =
    ((r_smc_currentstate == smc_lite_pkg::st_rw) & ws_zero & cste_zero) |
    ((r_smc_currentstate == smc_lite_pkg::st_float) & cste_zero);

  // Next access may load once the current one is on its final edge
  assign valid_access = new_access & mac_done &
                        ((r_smc_currentstate == smc_lite_pkg::st_idle) | smc_done);

  // Read byte captured while the strobe is still on
  assign latch_data = (r_smc_currentstate == smc_lite_pkg::st_rw) &
                      (r_ws_count[smc_lite_pkg::ws_w-1:smc_lite_pkg::edge_w] == '0) &
                      (r_ws_count >= r_oete_store);

  //--------------------------------------------------------------------
  // Counter enables
  //--------------------------------------------------------------------
  assign le_enable   = (smc_nextstate == smc_lite_pkg::st_le);
  assign cste_enable = (smc_nextstate == smc_lite_pkg::st_float);
  // Wait count reloads on rw entry and on rw to rw restart
  assign ws_enable   = (smc_nextstate == smc_lite_pkg::st_rw) &
                       ((r_smc_currentstate != smc_lite_pkg::st_rw) | ws_zero);
  assign smc_idle    = (smc_nextstate == smc_lite_pkg::st_idle);

  // Shared tail of rw and float once the beat is over
  always_comb
  begin
    if (!mac_done)
      follow = (r_csle_store != '0) ? smc_lite_pkg::st_le : smc_lite_pkg::st_rw;
    else if (new_access)
      follow = turnaround ? smc_lite_pkg::st_store : smc_lite_pkg::st_rw;
    else
      follow = smc_lite_pkg::st_idle;
  end

  //--------------------------------------------------------------------
  // Next state
  //--------------------------------------------------------------------
  always_comb
  begin
    case (r_smc_currentstate)
      smc_lite_pkg::st_idle:
        smc_nextstate = new_access ? smc_lite_pkg::st_store : smc_lite_pkg::st_idle;
      smc_lite_pkg::st_store:
      begin
        if (r_csle_count != '0)
          smc_nextstate = smc_lite_pkg::st_le;
        else
          smc_nextstate = smc_lite_pkg::st_rw;  // No leading edge
      end
      smc_lite_pkg::st_le:
      begin
        if (r_csle_count < 2'd2)
          smc_nextstate = smc_lite_pkg::st_rw;  // Last le cycle
        else
          smc_nextstate = smc_lite_pkg::st_le;
      end
      smc_lite_pkg::st_rw:
      begin
        if (!ws_zero)
          smc_nextstate = smc_lite_pkg::st_rw;     // Wait states left
        else if (!cste_zero)
          smc_nextstate = smc_lite_pkg::st_float;  // Trailing edge needed
        else
          smc_nextstate = follow;
      end
      smc_lite_pkg::st_float:
      begin
        if (!cste_zero)
          smc_nextstate = smc_lite_pkg::st_float;
        else
          smc_nextstate = follow;
      end
      default:
        smc_nextstate = smc_lite_pkg::st_idle;
    endcase
  end

  // State register
  always_ff @(posedge sys_clk8 or negedge n_sys_reset8)
  begin
    if (!n_sys_reset8)
      r_smc_currentstate <= smc_lite_pkg::st_idle;
    else
      r_smc_currentstate <= smc_nextstate;
  end

endmodule

/* hdl/smc_timing_counters.sv */
// Access timing counters
// Stored copies of the four timing settings
// Leading edge, wait state and trailing edge down-counters
`timescale 1ns/1ns

module smc_timing_counters (
  input  logic                            sys_clk8,
  input  logic                            n_sys_reset8,
  input  logic                            valid_access,
  input  logic                            le_enable,
  input  logic                            ws_enable,
  input  logic                            cste_enable,
  input  smc_lite_pkg::smc_state_t        r_smc_currentstate,
  input  logic [smc_lite_pkg::edge_w-1:0] cfg_csle,
  input  logic [smc_lite_pkg::edge_w-1:0] cfg_cste,
  input  logic [smc_lite_pkg::edge_w-1:0] cfg_oete,
  input  logic [smc_lite_pkg::ws_w-1:0]   cfg_ws,
  output logic [smc_lite_pkg::edge_w-1:0] r_csle_count,
  output logic [smc_lite_pkg::edge_w-1:0] r_cste_count,
  output logic [smc_lite_pkg::ws_w-1:0]   r_ws_count,
  output logic [smc_lite_pkg::edge_w-1:0] r_csle_store,
  output logic [smc_lite_pkg::edge_w-1:0] r_oete_store
);

  logic [smc_lite_pkg::edge_w-1:0] r_cste_store;
  logic [smc_lite_pkg::ws_w-1:0]   r_ws_store;
  logic                            in_le;  // Leading edge phase running
  logic                            in_rw;  // Strobe phase running

  assign in_le = (r_smc_currentstate == smc_lite_pkg::st_le);
  assign in_rw = (r_smc_currentstate == smc_lite_pkg::st_rw);

  //--------------------------------------------------------------------
  // Settings frozen for the whole access
  //--------------------------------------------------------------------
  always_ff @(posedge sys_clk8 or negedge n_sys_reset8)
  begin
    if (!n_sys_reset8)
    begin
      r_csle_store <= '0;
      r_cste_store <= '0;
      r_oete_store <= '0;
      r_ws_store   <= '0;
    end
    else if (valid_access)
    begin
      r_csle_store <= cfg_csle;
      r_cste_store <= cfg_cste;
      r_oete_store <= cfg_oete;
      r_ws_store   <= cfg_ws;
    end
  end

  //--------------------------------------------------------------------
  // Down-counters
  //--------------------------------------------------------------------
  always_ff @(posedge sys_clk8 or negedge n_sys_reset8)
  begin
    if (!n_sys_reset8)
    begin
      r_csle_count <= '0;
      r_cste_count <= '0;
      r_ws_count   <= '0;
    end
    else
    begin
      // Leading edge, loaded for store, reloaded on entry to le
      if (valid_access)
        r_csle_count <= cfg_csle;
      else if (le_enable && !in_le)
        r_csle_count <= r_csle_store;
      else if (le_enable && r_csle_count != '0)
        r_csle_count <= r_csle_count - 1'b1;

      // Wait states, one rw cycle per count plus one
      if (ws_enable)
        r_ws_count <= valid_access ? cfg_ws : r_ws_store;
      else if (in_rw && r_ws_count != '0)
        r_ws_count <= r_ws_count - 1'b1;

      // Trailing edge, held at the stored value outside float
      if (valid_access)
        r_cste_count <= cfg_cste;
      else if (!cste_enable)
        r_cste_count <= r_cste_store;
      else if (r_cste_count != '0)
        r_cste_count <= r_cste_count - 1'b1;  // Counts on float entry too
    end
  end

endmodule

/* hdl/smc_mac.sv */
// Multiple access unit
// Splits an access into 1, 2 or 4 byte beats
// Beat address and write byte, read data assembly, host done pulse
`timescale 1ns/1ns

module smc_mac (
  input  logic                                 sys_clk8,
  input  logic                                 n_sys_reset8,
  input  logic                                 valid_access,
  input  logic                                 smc_done,    // Beat finished
  input  logic                                 latch_data,  // Capture read byte
  input  logic [1:0]                           req_size,
  input  logic [smc_lite_pkg::host_addr_w-1:0] req_addr,
  input  logic [smc_lite_pkg::host_data_w-1:0] req_wdata,
  input  logic                                 n_read,
  input  logic [smc_lite_pkg::mem_data_w-1:0]  mem_rdata,
  output logic                                 mac_done,    // Last beat in progress
  output logic [smc_lite_pkg::host_addr_w-1:0] mem_addr,
  output logic [smc_lite_pkg::mem_data_w-1:0]  mem_wdata,
  output logic [smc_lite_pkg::host_data_w-1:0] host_rdata,
  output logic                                 host_done
);

  logic [1:0]                           beat;       // Current beat index
  logic [1:0]                           last_beat;  // Index of final beat
  logic                                 r_read;     // Access is a read
  logic [smc_lite_pkg::host_addr_w-1:0] base_addr;
  logic [smc_lite_pkg::host_data_w-1:0] wdata;
  logic [smc_lite_pkg::host_data_w-1:0] rd_buf;     // Bytes gathered so far
  logic [smc_lite_pkg::host_data_w-1:0] rd_next;

  assign mac_done  = (beat == last_beat);  // Also high with no access
  assign mem_addr  = base_addr + {{(smc_lite_pkg::host_addr_w-2){1'b0}}, beat};
  assign mem_wdata = wdata[beat*smc_lite_pkg::mem_data_w +: smc_lite_pkg::mem_data_w];

  // Read byte lands in its lane, lowest address in lane 0
  always_comb
  begin
    rd_next = rd_buf;
    if (latch_data && r_read)
      rd_next[beat*smc_lite_pkg::mem_data_w +: smc_lite_pkg::mem_data_w] = mem_rdata;
  end

  //--------------------------------------------------------------------
  // Beat sequencing
  //--------------------------------------------------------------------
  always_ff @(posedge sys_clk8 or negedge n_sys_reset8)
  begin
    if (!n_sys_reset8)
    begin
      beat      <= 2'd0;
      last_beat <= 2'd0;
      r_read    <= 1'b0;
      host_done <= 1'b0;
    end
    else
    begin
      host_done <= smc_done & mac_done;  // Edge after final beat
      if (valid_access)
      begin
        beat   <= 2'd0;
        r_read <= ~n_read;
        case (req_size)
          smc_lite_pkg::size_half: last_beat <= 2'd1;
          smc_lite_pkg::size_word: last_beat <= 2'd3;
          default:                 last_beat <= 2'd0;  // Byte, unused code
        endcase
      end
      else if (smc_done && !mac_done)
        beat <= beat + 2'd1;
    end
  end

  // Access payload and read data
  always_ff @(posedge sys_clk8)
  begin
    if (valid_access)
    begin
      base_addr <= req_addr;
      wdata     <= req_wdata;
      rd_buf    <= '0;  // Unused upper lanes read as zero
    end
    else
      rd_buf <= rd_next;
    if (smc_done && mac_done && r_read)
      host_rdata <= rd_next;  // Held until the next read completes
  end

endmodule

/* hdl/smc_host_port.sv */
// Host request port
// Single pending request register with ready level
// Registered direction and bank of the access in progress
`timescale 1ns/1ns

module smc_host_port (
  input  logic                                 sys_clk8,
  input  logic                                 n_sys_reset8,
  input  logic                                 host_req,     // Request pulse
  input  logic                                 host_write,
  input  logic                                 host_bank,
  input  logic [1:0]                           host_size,
  input  logic [smc_lite_pkg::host_addr_w-1:0] host_addr,
  input  logic [smc_lite_pkg::host_data_w-1:0] host_wdata,
  input  logic                                 valid_access, // Request taken by FSM
  output logic                                 new_access,
  output logic                                 n_read,       // Pending direction, low = read
  output logic                                 n_r_read,     // Direction in progress
  output logic                                 cs,           // Pending bank
  output logic                                 r_cs,         // Bank in progress
  output logic                                 host_ready,
  output logic [1:0]                           req_size,
  output logic [smc_lite_pkg::host_addr_w-1:0] req_addr,
  output logic [smc_lite_pkg::host_data_w-1:0] req_wdata
);

  logic pending;   // Request held, not yet started
  logic take_req;  // Request accepted this cycle

  assign take_req   = host_req & ~pending;
  assign new_access = pending;
  assign host_ready = ~pending;  // Room for one request

  // Pending flag and the copies compared for turnaround
  always_ff @(posedge sys_clk8 or negedge n_sys_reset8)
  begin
    if (!n_sys_reset8)
    begin
      pending  <= 1'b0;
      n_r_read <= 1'b1;
      r_cs     <= 1'b0;
    end
    else if (valid_access)
    begin
      pending  <= 1'b0;
      n_r_read <= n_read;  // Access now in progress
      r_cs     <= cs;
    end
    else if (take_req)
      pending <= 1'b1;
  end

  // Request payload
  always_ff @(posedge sys_clk8)
  begin
    if (take_req)
    begin
      n_read    <= host_write;  // Write means no read
      cs        <= host_bank;
      req_size  <= host_size;
      req_addr  <= host_addr;
      req_wdata <= host_wdata;
    end
  end

endmodule

/* hdl/smc_lite_pkg.sv */
// Static memory controller shared definitions
// Bus widths, timing count widths, access size codes
// One-hot state encoding of the access FSM
package smc_lite_pkg;

  //--------------------------------------------------------------------
  // Widths
  //--------------------------------------------------------------------
  localparam int host_addr_w = 16;  // Host byte address
  localparam int host_data_w = 32;  // Host data, up to one word
  localparam int mem_data_w  = 8;   // External byte bus
  localparam int ws_w        = 8;   // Wait state count
  localparam int edge_w      = 2;   // Leading and trailing edge counts
  localparam int state_w     = 5;   // One-hot state vector

  // Access size codes, number of memory beats in brackets
  localparam logic [1:0] size_byte = 2'b00;  // 1 beat
  localparam logic [1:0] size_half = 2'b01;  // 2 beats
  localparam logic [1:0] size_word = 2'b10;  // 4 beats

  //--------------------------------------------------------------------
  // Access FSM states
  //--------------------------------------------------------------------
  typedef enum logic [state_w-1:0] {
    st_idle  = 5'b00001,  // No access, strobes off
    st_store = 5'b00010,  // Access values being stored
    st_le    = 5'b00100,  // Chip select leading edge
    st_rw    = 5'b01000,  // Read or write strobe phase
    st_float = 5'b10000   // Chip select trailing edge
  } smc_state_t;

endpackage
